//--- logic/bpu_pkg.sv
package bpu_pkg;

    // widths
    localparam int XLEN       = 32;
    localparam int HIST_W     = 16;

    // direction tables
    localparam int BIM_ENTRIES = 512;
    localparam int BIM_IDX_W   = $clog2(BIM_ENTRIES);
    localparam int TAG_ENTRIES = 256;            // per tagged table
    localparam int TAG_IDX_W   = $clog2(TAG_ENTRIES);
    localparam int TAG_W       = 10;
    localparam int PART_TAG_W  = 6;              // only the top bits take part in a match

    // target buffer
    localparam int BTB_ENTRIES = 256;
    localparam int BTB_IDX_W   = $clog2(BTB_ENTRIES);
    localparam int BTB_TAG_W   = 22;

    // stack pointer is one bit wider than the index so a full count fits
    localparam int RAS_DEPTH  = 32;
    localparam int RAS_IDX_W  = $clog2(RAS_DEPTH);
    localparam int RAS_PTR_W  = 6;

    // 2-bit saturating counter states
    localparam logic [1:0] CTR_INIT     = 2'b01;
    localparam logic [1:0] CTR_ALLOC_T  = 2'b10;
    localparam logic [1:0] CTR_ALLOC_N  = 2'b01;
    localparam logic [1:0] CTR_STRONG_T = 2'b11;
    localparam logic [1:0] CTR_STRONG_N = 2'b00;

    // rv32 opcodes and link registers
    localparam logic [6:0] OP_BRANCH = 7'b1100011;
    localparam logic [6:0] OP_JAL    = 7'b1101111;
    localparam logic [6:0] OP_JALR   = 7'b1100111;
    localparam logic [4:0] REG_ZERO  = 5'd0;
    localparam logic [4:0] REG_RA    = 5'd1;
    localparam logic [4:0] REG_T0    = 5'd5;  // alternate link register

    typedef enum logic [1:0] {
        PROV_BIM = 2'd0,
        PROV_T0  = 2'd1,
        PROV_T1  = 2'd2
    } provider_e;

    // conditional branch layout
    typedef struct packed {
        logic       imm12;
        logic [5:0] imm10_5;
        logic [4:0] rs2;
        logic [4:0] rs1;
        logic [2:0] funct3;
        logic [3:0] imm4_1;
        logic       imm11;
        logic [6:0] opcode;
    } b_fmt_s;

    // jal layout
    typedef struct packed {
        logic       imm20;
        logic [9:0] imm10_1;
        logic       imm11;
        logic [7:0] imm19_12;
        logic [4:0] rd;
        logic [6:0] opcode;
    } j_fmt_s;

    typedef union packed {
        b_fmt_s b;
        j_fmt_s j;
    } inst_word_u;

    typedef struct packed {
        logic            is_branch;
        logic            is_jal;
        logic            is_jalr;
        logic            is_ret;
        logic [XLEN-1:0] b_offset;
        logic [XLEN-1:0] j_offset;
    } inst_class_s;

    // resolved branch coming back from execute
    typedef struct packed {
        logic              valid;
        logic              taken;
        logic              correct;
        logic [XLEN-1:0]   pc;
        logic [HIST_W-1:0] history;   // history seen at prediction time
        provider_e         provider;
        logic [XLEN-1:0]   target;
        logic              is_ret;
    } ex_fb_s;

    typedef struct packed {
        logic      taken;
        provider_e provider;
    } dir_pred_s;

    typedef struct packed {
        logic            hit;
        logic [XLEN-1:0] target;
    } btb_look_s;

    typedef struct packed {
        logic            nonempty;
        logic [XLEN-1:0] top;
    } ras_top_s;

endpackage

//--- logic/inst_decoder.sv
`timescale 1ns/1ps

module inst_decoder (
    input  bpu_pkg::inst_word_u  inst_i,
    output bpu_pkg::inst_class_s cls_o
);
    import bpu_pkg::*;

    logic link_rs1;
    logic rd_zero;

    // b view gives rs1, j view gives rd
    assign link_rs1 = (inst_i.b.rs1 == REG_RA) || (inst_i.b.rs1 == REG_T0);
    assign rd_zero  = (inst_i.j.rd == REG_ZERO);

    always_comb begin
        cls_o.is_branch = (inst_i.b.opcode == OP_BRANCH);
        cls_o.is_jal    = (inst_i.j.opcode == OP_JAL);
        cls_o.is_jalr   = (inst_i.b.opcode == OP_JALR);
        cls_o.is_ret    = cls_o.is_jalr && link_rs1 && rd_zero;

        // sign-extended immediates, bit 0 always zero
        cls_o.b_offset = {{20{inst_i.b.imm12}},
                          inst_i.b.imm11,
                          inst_i.b.imm10_5,
                          inst_i.b.imm4_1,
                          1'b0};
        cls_o.j_offset = {{12{inst_i.j.imm20}},
                          inst_i.j.imm19_12,
                          inst_i.j.imm11,
                          inst_i.j.imm10_1,
                          1'b0};
    end

endmodule

//--- logic/tage_direction.sv
`timescale 1ns/1ps

module tage_direction (
    input  logic                        clk,
    input  logic                        rst,
    input  logic [bpu_pkg::XLEN-1:0]    pc_i,
    input  logic [bpu_pkg::HIST_W-1:0]  hist_i,
    input  bpu_pkg::ex_fb_s             fb_i,
    output bpu_pkg::dir_pred_s          pred_o
);
    import bpu_pkg::*;

    logic [1:0]       bim_ctr [BIM_ENTRIES];
    logic [TAG_W-1:0] t0_tag  [TAG_ENTRIES];
    logic [1:0]       t0_ctr  [TAG_ENTRIES];
    logic [TAG_W-1:0] t1_tag  [TAG_ENTRIES];
    logic [1:0]       t1_ctr  [TAG_ENTRIES];

    // lookup side
    logic [BIM_IDX_W-1:0] bim_idx;
    logic [TAG_IDX_W-1:0] t0_idx, t1_idx;
    logic [TAG_W-1:0]     t0_key, t1_key;
    logic                 t0_match, t1_match;

    // update side recomputed from the feedback
    logic [BIM_IDX_W-1:0] bim_idx_u;
    logic [TAG_IDX_W-1:0] t0_idx_u, t1_idx_u;
    logic [TAG_W-1:0]     t0_key_u, t1_key_u;

    // t0 folds the short history slice into the index and the upper slice into the tag
    function automatic logic [TAG_IDX_W-1:0] t0_index(input logic [XLEN-1:0] pc,
                                                       input logic [HIST_W-1:0] hist);
        return pc[TAG_IDX_W-1:0] ^ hist[TAG_IDX_W-1:0];
    endfunction

    function automatic logic [TAG_IDX_W-1:0] t1_index(input logic [XLEN-1:0] pc,
                                                       input logic [HIST_W-1:0] hist);
        return pc[TAG_IDX_W-1:0] ^ hist[HIST_W-1 -: TAG_IDX_W];
    endfunction

    function automatic logic [TAG_W-1:0] t0_tag_of(input logic [XLEN-1:0] pc,
                                                    input logic [HIST_W-1:0] hist);
        return pc[TAG_IDX_W+TAG_W-1:TAG_IDX_W] ^ hist[HIST_W-1 -: TAG_W];
    endfunction

    function automatic logic [TAG_W-1:0] t1_tag_of(input logic [XLEN-1:0] pc,
                                                    input logic [HIST_W-1:0] hist);
        return pc[TAG_IDX_W+TAG_W-1:TAG_IDX_W] ^
               {{(TAG_W-TAG_IDX_W){1'b0}}, hist[TAG_IDX_W-1:0]};
    endfunction

    // saturate one step toward the outcome
    function automatic logic [1:0] ctr_step(input logic [1:0] ctr, input logic taken);
        logic [1:0] nxt;
        nxt = ctr;
        if (taken && ctr != CTR_STRONG_T)
            nxt = ctr + 2'd1;
        else if (!taken && ctr != CTR_STRONG_N)
            nxt = ctr - 2'd1;
        return nxt;
    endfunction

    assign bim_idx = pc_i[BIM_IDX_W:1];
    assign t0_idx  = t0_index(pc_i, hist_i);
    assign t1_idx  = t1_index(pc_i, hist_i);
    assign t0_key  = t0_tag_of(pc_i, hist_i);
    assign t1_key  = t1_tag_of(pc_i, hist_i);

    assign t0_match = (t0_tag[t0_idx][TAG_W-1 -: PART_TAG_W] == t0_key[TAG_W-1 -: PART_TAG_W]);
    assign t1_match = (t1_tag[t1_idx][TAG_W-1 -: PART_TAG_W] == t1_key[TAG_W-1 -: PART_TAG_W]);

    always_comb begin
        if (t1_match) begin          // longest history wins
            pred_o.provider = PROV_T1;
            pred_o.taken    = t1_ctr[t1_idx][1];
        end else if (t0_match) begin
            pred_o.provider = PROV_T0;
            pred_o.taken    = t0_ctr[t0_idx][1];
        end else begin
            pred_o.provider = PROV_BIM;
            pred_o.taken    = bim_ctr[bim_idx][1];
        end
    end

    assign bim_idx_u = fb_i.pc[BIM_IDX_W:1];
    assign t0_idx_u  = t0_index(fb_i.pc, fb_i.history);
    assign t1_idx_u  = t1_index(fb_i.pc, fb_i.history);
    assign t0_key_u  = t0_tag_of(fb_i.pc, fb_i.history);
    assign t1_key_u  = t1_tag_of(fb_i.pc, fb_i.history);

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            for (int i = 0; i < BIM_ENTRIES; i++)
                bim_ctr[i] <= CTR_INIT;
            for (int i = 0; i < TAG_ENTRIES; i++) begin
                t0_tag[i] <= '0;
                t0_ctr[i] <= CTR_INIT;
                t1_tag[i] <= '0;
                t1_ctr[i] <= CTR_INIT;
            end
        end else if (fb_i.valid) begin
            bim_ctr[bim_idx_u] <= ctr_step(bim_ctr[bim_idx_u], fb_i.taken);

            if (fb_i.correct) begin
                case (fb_i.provider)
                    PROV_T1: t1_ctr[t1_idx_u] <= ctr_step(t1_ctr[t1_idx_u], fb_i.taken);
                    PROV_T0: t0_ctr[t0_idx_u] <= ctr_step(t0_ctr[t0_idx_u], fb_i.taken);
                    default: ;                       // bimodal already handled
                endcase
            end else begin
                case (fb_i.provider)
                    PROV_T1: t1_ctr[t1_idx_u] <= fb_i.taken ? CTR_STRONG_T : CTR_STRONG_N;
                    PROV_T0: t0_ctr[t0_idx_u] <= fb_i.taken ? CTR_STRONG_T : CTR_STRONG_N;
                    default: begin
                        // bimodal miss allocates into t1 first and t0 otherwise
                        if (t1_tag[t1_idx_u] != t1_key_u) begin
                            t1_tag[t1_idx_u] <= t1_key_u;
                            t1_ctr[t1_idx_u] <= fb_i.taken ? CTR_ALLOC_T : CTR_ALLOC_N;
                        end else if (t0_tag[t0_idx_u] != t0_key_u) begin
                            t0_tag[t0_idx_u] <= t0_key_u;
                            t0_ctr[t0_idx_u] <= fb_i.taken ? CTR_ALLOC_T : CTR_ALLOC_N;
                        end
                    end
                endcase
            end
        end
    end

endmodule

//--- logic/branch_target_buffer.sv
`timescale 1ns/1ps

module branch_target_buffer (
    input  logic                     clk,
    input  logic                     rst,
    input  logic [bpu_pkg::XLEN-1:0] pc_i,
    input  bpu_pkg::ex_fb_s          fb_i,
    output bpu_pkg::btb_look_s       look_o
);
    import bpu_pkg::*;

    logic                 btb_valid  [BTB_ENTRIES];
    logic [BTB_TAG_W-1:0] btb_tag    [BTB_ENTRIES];
    logic [XLEN-1:0]      btb_target [BTB_ENTRIES];

    logic [BTB_IDX_W-1:0] rd_idx, wr_idx;
    logic [BTB_TAG_W-1:0] rd_tag, wr_tag;

    // word aligned index, upper pc bits as tag
    assign rd_idx = pc_i[BTB_IDX_W+1:2];
    assign rd_tag = pc_i[XLEN-1 -: BTB_TAG_W];
    assign wr_idx = fb_i.pc[BTB_IDX_W+1:2];
    assign wr_tag = fb_i.pc[XLEN-1 -: BTB_TAG_W];

    assign look_o.hit    = btb_valid[rd_idx] && (btb_tag[rd_idx] == rd_tag);
    assign look_o.target = btb_target[rd_idx];

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            for (int i = 0; i < BTB_ENTRIES; i++) begin
                btb_valid[i]  <= 1'b0;
                btb_tag[i]    <= '0;
                btb_target[i] <= '0;
            end
        end else if (fb_i.valid && fb_i.taken) begin   // only taken branches are worth a slot
            btb_valid[wr_idx]  <= 1'b1;
            btb_tag[wr_idx]    <= wr_tag;
            btb_target[wr_idx] <= fb_i.target;
        end
    end

endmodule

//--- logic/return_stack.sv
`timescale 1ns/1ps

module return_stack (
    input  logic                     clk,
    input  logic                     rst,
    input  logic                     push_i,
    input  logic [bpu_pkg::XLEN-1:0] push_data_i,
    input  logic                     pop_i,
    output bpu_pkg::ras_top_s        top_o
);
    import bpu_pkg::*;

    logic [XLEN-1:0]      stack [RAS_DEPTH];
    logic [RAS_PTR_W-1:0] sp;        // next free slot
    logic [RAS_PTR_W-1:0] sp_pop;    // pointer after this cycle's pop
    logic [RAS_IDX_W-1:0] top_idx;
    logic                 push_ok;

    assign top_idx        = RAS_IDX_W'(sp - RAS_PTR_W'(1));
    assign top_o.nonempty = (sp != '0);
    assign top_o.top      = stack[top_idx];

    always_comb begin
        sp_pop = sp;
        if (pop_i && sp != '0)
            sp_pop = sp - RAS_PTR_W'(1);   // pop on empty stack is ignored
    end

    // push lands on the slot freed by a same-cycle pop
    assign push_ok = push_i && (sp_pop < RAS_PTR_W'(RAS_DEPTH));

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            sp <= '0;
            for (int i = 0; i < RAS_DEPTH; i++)
                stack[i] <= '0;
        end else begin
            if (push_ok)
                stack[sp_pop[RAS_IDX_W-1:0]] <= push_data_i;
            sp <= push_ok ? sp_pop + RAS_PTR_W'(1) : sp_pop;  // full stack drops the push
        end
    end

endmodule

//--- logic/pred_select.sv
`timescale 1ns/1ps

module pred_select (
    input  logic [bpu_pkg::XLEN-1:0] pc_i,
    input  bpu_pkg::inst_class_s     cls_i,
    input  bpu_pkg::dir_pred_s       dir_i,
    input  bpu_pkg::btb_look_s       btb_i,
    input  bpu_pkg::ras_top_s        ras_i,
    output logic                     branch_or_not_o,
    output logic [bpu_pkg::XLEN-1:0] pdt_pc_o,
    output logic                     pdt_res_o
);
    import bpu_pkg::*;

    logic [XLEN-1:0] seq_pc;

    assign seq_pc = pc_i + XLEN'(4);

    always_comb begin
        branch_or_not_o = cls_i.is_branch || cls_i.is_jal || cls_i.is_jalr;
        pdt_pc_o        = seq_pc;
        pdt_res_o       = 1'b0;

        if (cls_i.is_ret) begin
            // empty stack leaves the ret as not taken
            if (ras_i.nonempty) begin
                pdt_res_o = 1'b1;
                pdt_pc_o  = ras_i.top;
            end
        end else if (cls_i.is_jal) begin
            pdt_res_o = 1'b1;
            pdt_pc_o  = btb_i.hit ? btb_i.target : pc_i + cls_i.j_offset;
        end else if (cls_i.is_branch || cls_i.is_jalr) begin
            pdt_res_o = dir_i.taken;
            if (dir_i.taken) begin
                if (btb_i.hit)
                    pdt_pc_o = btb_i.target;
                else if (cls_i.is_branch)
                    pdt_pc_o = pc_i + cls_i.b_offset;   // jalr without btb stays at pc+4
            end
        end
    end

endmodule

//--- logic/bpu.sv
`timescale 1ns/1ps

module bpu (
    input  logic                       clk,
    input  logic                       rst,
    // fetch
    input  logic [bpu_pkg::XLEN-1:0]   if_pc_i,
    input  logic [bpu_pkg::XLEN-1:0]   if_inst_i,
    // execute feedback
    input  logic                       ex_branch_valid_i,
    input  logic                       ex_branch_taken_i,
    input  logic                       ex_pdt_true_i,
    input  logic [bpu_pkg::XLEN-1:0]   ex_pc_i,
    input  logic [bpu_pkg::HIST_W-1:0] ex_history_i,
    input  bpu_pkg::provider_e         ex_provider_i,
    input  logic [bpu_pkg::XLEN-1:0]   ex_target_i,
    input  logic [bpu_pkg::XLEN-1:0]   ex_inst_i,
    // call seen in decode
    input  logic                       id_ras_push_valid_i,
    input  logic [bpu_pkg::XLEN-1:0]   id_ras_push_data_i,
    input  logic                       ex_stall_valid_i,
    // prediction
    output logic                       branch_or_not_o,
    output logic [bpu_pkg::XLEN-1:0]   pdt_pc_o,
    output logic                       pdt_res_o,
    output logic [bpu_pkg::HIST_W-1:0] history_o,
    output bpu_pkg::provider_e         provider_o
);
    import bpu_pkg::*;

    logic [HIST_W-1:0] history;
    inst_class_s       if_cls, ex_cls;
    ex_fb_s            ex_fb;
    dir_pred_s         dir_pred;
    btb_look_s         btb_look;
    ras_top_s          ras_top;
    logic              ras_pop, ras_push;

    assign ex_fb = '{valid:    ex_branch_valid_i,
                     taken:    ex_branch_taken_i,
                     correct:  ex_pdt_true_i,
                     pc:       ex_pc_i,
                     history:  ex_history_i,
                     provider: ex_provider_i,
                     target:   ex_target_i,
                     is_ret:   ex_cls.is_ret};

    // stall freezes only the stack
    assign ras_pop  = ex_fb.valid && ex_fb.taken && ex_fb.is_ret && !ex_stall_valid_i;
    assign ras_push = id_ras_push_valid_i && !ex_stall_valid_i;

    always_ff @(posedge clk or posedge rst) begin
        if (rst)
            history <= '0;
        else if (ex_fb.valid)
            history <= {history[HIST_W-2:0], ex_fb.taken};
    end

    assign history_o  = history;
    assign provider_o = dir_pred.provider;

    inst_decoder u_if_dec (.inst_i(if_inst_i), .cls_o(if_cls));
    inst_decoder u_ex_dec (.inst_i(ex_inst_i), .cls_o(ex_cls));

    tage_direction u_dir (
        .clk(clk), .rst(rst), .pc_i(if_pc_i), .hist_i(history),
        .fb_i(ex_fb), .pred_o(dir_pred)
    );

    branch_target_buffer u_btb (
        .clk(clk), .rst(rst), .pc_i(if_pc_i), .fb_i(ex_fb), .look_o(btb_look)
    );

    return_stack u_ras (
        .clk(clk), .rst(rst), .push_i(ras_push), .push_data_i(id_ras_push_data_i),
        .pop_i(ras_pop), .top_o(ras_top)
    );

    pred_select u_sel (
        .pc_i(if_pc_i), .cls_i(if_cls), .dir_i(dir_pred), .btb_i(btb_look),
        .ras_i(ras_top), .branch_or_not_o(branch_or_not_o),
        .pdt_pc_o(pdt_pc_o), .pdt_res_o(pdt_res_o)
    );

endmodule

//--- bench/bpu_model.svh
`ifndef BPU_MODEL_SVH
`define BPU_MODEL_SVH

// reference copy of every predictor table
logic [1:0]           m_bim     [BIM_ENTRIES];
logic [TAG_W-1:0]     m_t0_tag  [TAG_ENTRIES];
logic [1:0]           m_t0_ctr  [TAG_ENTRIES];
logic [TAG_W-1:0]     m_t1_tag  [TAG_ENTRIES];
logic [1:0]           m_t1_ctr  [TAG_ENTRIES];
logic                 m_btb_v   [BTB_ENTRIES];
logic [BTB_TAG_W-1:0] m_btb_tag [BTB_ENTRIES];
logic [XLEN-1:0]      m_btb_tgt [BTB_ENTRIES];
logic [XLEN-1:0]      m_ras     [RAS_DEPTH];
logic [5:0]           m_sp;       // next free stack slot
logic [HIST_W-1:0]    m_hist;

// expected prediction for the current fetch
logic                 exp_bon;
logic                 exp_res;
logic [XLEN-1:0]      exp_pc;
provider_e            exp_prov;

function automatic logic [1:0] sat_step(input logic [1:0] c, input logic t);
    if (t)
        return (c == 2'b11) ? c : c + 2'b01;
    return (c == 2'b00) ? c : c - 2'b01;
endfunction

// jalr x0 through x1 or x5
function automatic logic is_ret_word(input logic [31:0] w);
    return (w[6:0] == 7'b1100111) && (w[11:7] == 5'd0) &&
           ((w[19:15] == 5'd1) || (w[19:15] == 5'd5));
endfunction

task automatic clear_tables();
    for (int i = 0; i < BIM_ENTRIES; i++)
        m_bim[i] = CTR_INIT;
    for (int i = 0; i < TAG_ENTRIES; i++) begin
        m_t0_tag[i] = '0;
        m_t0_ctr[i] = CTR_INIT;
        m_t1_tag[i] = '0;
        m_t1_ctr[i] = CTR_INIT;
    end
    for (int i = 0; i < BTB_ENTRIES; i++) begin
        m_btb_v[i]   = 1'b0;
        m_btb_tag[i] = '0;
        m_btb_tgt[i] = '0;
    end
    for (int i = 0; i < RAS_DEPTH; i++)
        m_ras[i] = '0;
    m_sp   = '0;
    m_hist = '0;
endtask

task automatic predict_fetch(input logic [31:0] pc, input logic [31:0] inst);
    logic [7:0]  i0, i1, bi;
    logic [9:0]  k0, k1;
    logic [5:0]  top;
    logic        br, jal, jalr, ret, dir, hit;
    logic [31:0] boff, joff;
    i0 = pc[7:0] ^ m_hist[7:0];
    i1 = pc[7:0] ^ m_hist[15:8];
    k0 = pc[17:8] ^ m_hist[15:6];
    k1 = pc[17:8] ^ {2'b00, m_hist[7:0]};
    if (m_t1_tag[i1][9:4] == k1[9:4]) begin
        exp_prov = PROV_T1;
        dir      = m_t1_ctr[i1][1];
    end else if (m_t0_tag[i0][9:4] == k0[9:4]) begin
        exp_prov = PROV_T0;
        dir      = m_t0_ctr[i0][1];
    end else begin
        exp_prov = PROV_BIM;
        dir      = m_bim[pc[9:1]][1];
    end
    br   = (inst[6:0] == 7'b1100011);
    jal  = (inst[6:0] == 7'b1101111);
    jalr = (inst[6:0] == 7'b1100111);
    ret  = is_ret_word(inst);
    boff = {{20{inst[31]}}, inst[7], inst[30:25], inst[11:8], 1'b0};
    joff = {{12{inst[31]}}, inst[19:12], inst[20], inst[30:21], 1'b0};
    bi   = pc[9:2];
    hit  = m_btb_v[bi] && (m_btb_tag[bi] == pc[31:10]);
    top  = m_sp - 6'd1;
    exp_bon = br || jal || jalr;
    exp_pc  = pc + 32'd4;
    exp_res = 1'b0;
    if (ret) begin
        if (m_sp != 6'd0) begin
            exp_res = 1'b1;
            exp_pc  = m_ras[top[4:0]];
        end
    end else if (jal) begin
        exp_res = 1'b1;
        exp_pc  = hit ? m_btb_tgt[bi] : pc + joff;
    end else if (br || jalr) begin
        exp_res = dir;
        if (dir && hit)
            exp_pc = m_btb_tgt[bi];
        else if (dir && br)
            exp_pc = pc + boff;
    end
endtask

// state change at one rising edge
task automatic learn_feedback(input logic valid, input logic taken, input logic correct,
                              input logic [31:0] pc, input logic [15:0] h,
                              input provider_e prov, input logic [31:0] target,
                              input logic [31:0] inst, input logic push,
                              input logic [31:0] pdata, input logic stall);
    logic [7:0] i0, i1;
    logic [9:0] k0, k1;
    i0 = pc[7:0] ^ h[7:0];
    i1 = pc[7:0] ^ h[15:8];
    k0 = pc[17:8] ^ h[15:6];
    k1 = pc[17:8] ^ {2'b00, h[7:0]};
    if (valid) begin
        m_bim[pc[9:1]] = sat_step(m_bim[pc[9:1]], taken);
        if (correct) begin
            if (prov == PROV_T1)
                m_t1_ctr[i1] = sat_step(m_t1_ctr[i1], taken);
            else if (prov == PROV_T0)
                m_t0_ctr[i0] = sat_step(m_t0_ctr[i0], taken);
        end else if (prov == PROV_T1) begin
            m_t1_ctr[i1] = taken ? CTR_STRONG_T : CTR_STRONG_N;
        end else if (prov == PROV_T0) begin
            m_t0_ctr[i0] = taken ? CTR_STRONG_T : CTR_STRONG_N;
        end else if (m_t1_tag[i1] != k1) begin
            m_t1_tag[i1] = k1;
            m_t1_ctr[i1] = taken ? CTR_ALLOC_T : CTR_ALLOC_N;
        end else if (m_t0_tag[i0] != k0) begin
            m_t0_tag[i0] = k0;
            m_t0_ctr[i0] = taken ? CTR_ALLOC_T : CTR_ALLOC_N;
        end
        if (taken) begin
            m_btb_v[pc[9:2]]   = 1'b1;
            m_btb_tag[pc[9:2]] = pc[31:10];
            m_btb_tgt[pc[9:2]] = target;
        end
        m_hist = {m_hist[14:0], taken};
    end
    // pop first, then push into the freed slot
    if (valid && taken && is_ret_word(inst) && !stall && m_sp != 6'd0)
        m_sp = m_sp - 6'd1;
    if (push && !stall && m_sp < 6'd32) begin
        m_ras[m_sp[4:0]] = pdata;
        m_sp = m_sp + 6'd1;
    end
endtask

`endif

//--- bench/tb_bpu.sv
`timescale 1ns/1ps

module tb_bpu;
    import bpu_pkg::*;

    localparam int          MAX_WAIT = 50;
    localparam logic [31:0] RET_WORD = 32'h0000_8067;   // jalr x0, 0(x1)

    logic              clk, rst;
    logic [31:0]       if_pc, if_inst;
    logic              ex_valid, ex_taken, ex_correct;
    logic [31:0]       ex_pc, ex_target, ex_inst;
    logic [15:0]       ex_history;
    provider_e         ex_provider;
    logic              push_valid, stall;
    logic [31:0]       push_data;
    logic              branch_or_not, pdt_res;
    logic [31:0]       pdt_pc;
    logic [15:0]       history;
    provider_e         provider;
    int                seed;

`include "bpu_model.svh"

    bpu dut0 (
        .clk(clk), .rst(rst), .if_pc_i(if_pc), .if_inst_i(if_inst),
        .ex_branch_valid_i(ex_valid), .ex_branch_taken_i(ex_taken),
        .ex_pdt_true_i(ex_correct), .ex_pc_i(ex_pc), .ex_history_i(ex_history),
        .ex_provider_i(ex_provider), .ex_target_i(ex_target), .ex_inst_i(ex_inst),
        .id_ras_push_valid_i(push_valid), .id_ras_push_data_i(push_data),
        .ex_stall_valid_i(stall), .branch_or_not_o(branch_or_not), .pdt_pc_o(pdt_pc),
        .pdt_res_o(pdt_res), .history_o(history), .provider_o(provider)
    );

    always #5 clk = ~clk;

    initial begin
        rst = 1'b1;
        repeat (8) @(posedge clk);
        @(negedge clk);
        rst = 1'b0;
    end

    task automatic check_val(input string name, input logic [31:0] got, input logic [31:0] want);
        if (got !== want) begin
            $display("Fail %s: got %h, expected %h", name, got, want);
            $display("CHECKS FAILED");
            $fatal(1, "value mismatch");
        end
    endtask

    function automatic logic [31:0] enc_branch(input logic [12:0] off);
        return {off[12], off[10:5], 5'd2, 5'd1, 3'b000, off[4:1], off[11], 7'b1100011};
    endfunction

    function automatic logic [31:0] enc_jal(input logic [20:0] off);
        return {off[20], off[10:1], off[11], off[19:12], 5'd1, 7'b1101111};
    endfunction

    // one fetch with execute resolving that same fetch
    task automatic run_cycle(input logic [31:0] pc, input logic [31:0] inst,
                             input logic fb_valid, input logic fb_taken,
                             input logic [31:0] fb_target, input logic push,
                             input logic [31:0] pdata, input logic stl);
        @(negedge clk);
        check_val("history_o", 32'(history), 32'(m_hist));
        predict_fetch(pc, inst);
        if_pc       = pc;
        if_inst     = inst;
        ex_valid    = fb_valid;
        ex_taken    = fb_taken;
        ex_correct  = (exp_res == fb_taken);
        ex_pc       = pc;
        ex_history  = m_hist;
        ex_provider = exp_prov;
        ex_target   = fb_target;
        ex_inst     = inst;
        push_valid  = push;
        push_data   = pdata;
        stall       = stl;
        #1;
        check_val("branch_or_not_o", 32'(branch_or_not), 32'(exp_bon));
        check_val("pdt_res_o", 32'(pdt_res), 32'(exp_res));
        check_val("pdt_pc_o", pdt_pc, exp_pc);
        check_val("provider_o", 32'(provider), 32'(exp_prov));
        learn_feedback(fb_valid, fb_taken, ex_correct, pc, ex_history, exp_prov, fb_target,
                       inst, push, pdata, stl);
    endtask

    initial begin
        logic [31:0] r, r2, pc, tgt;
        int          waited;
        seed        = 32'he647_cf3d;
        clk         = 1'b0;
        if_pc       = '0;
        if_inst     = '0;
        ex_valid    = 1'b0;
        ex_taken    = 1'b0;
        ex_correct  = 1'b0;
        ex_pc       = '0;
        ex_history  = '0;
        ex_provider = PROV_BIM;
        ex_target   = '0;
        ex_inst     = '0;
        push_valid  = 1'b0;
        push_data   = '0;
        stall       = 1'b0;
        clear_tables();

        waited = 0;
        while (rst !== 1'b0 && waited < MAX_WAIT) begin
            @(posedge clk);
            waited++;
        end
        if (rst !== 1'b0) begin
            $display("reset was never released");
            $display("CHECKS FAILED");
            $fatal(1, "reset timeout");
        end

        // addi then a jal at a fresh pc
        run_cycle(32'h0000_0100, 32'h0010_0093, 1'b0, 1'b0, '0, 1'b0, '0, 1'b0);
        check_val("history_o", 32'(history), 32'h0);
        check_val("branch_or_not_o", 32'(branch_or_not), 32'h0);
        check_val("pdt_pc_o", pdt_pc, 32'h0000_0104);
        run_cycle(32'h0000_2000, enc_jal(21'h40), 1'b0, 1'b0, '0, 1'b0, '0, 1'b0);
        check_val("pdt_res_o", 32'(pdt_res), 32'h1);
        check_val("pdt_pc_o", pdt_pc, 32'h0000_2040);

        // btb fill, hit, then same index with another tag
        pc  = 32'h0000_3a44;
        tgt = 32'h0000_7710;
        run_cycle(pc, enc_branch(13'h020), 1'b1, 1'b1, tgt, 1'b0, '0, 1'b0);
        run_cycle(pc, enc_branch(13'h020), 1'b0, 1'b0, '0, 1'b0, '0, 1'b0);
        check_val("pdt_res_o", 32'(pdt_res), 32'h1);
        check_val("pdt_pc_o", pdt_pc, tgt);
        run_cycle(pc, enc_jal(21'h100), 1'b0, 1'b0, '0, 1'b0, '0, 1'b0);
        check_val("pdt_pc_o", pdt_pc, tgt);
        run_cycle(pc ^ 32'h0000_1000, enc_jal(21'h100), 1'b0, 1'b0, '0, 1'b0, '0, 1'b0);
        check_val("pdt_pc_o", pdt_pc, (pc ^ 32'h0000_1000) + 32'h100);

        // conditional branches over a few pcs
        for (int n = 0; n < 2000; n++) begin
            r  = $random(seed);
            r2 = $random(seed);
            pc = 32'h0000_8000 + 32'(r[2:0]) * 32'h24;
            run_cycle(pc, enc_branch({r[14:3], 1'b0}), 1'b1, r[15], {r2[31:2], 2'b00},
                      1'b0, '0, 1'b0);
        end

        // push past capacity, then stalled traffic, then drain
        for (int n = 0; n < 40; n++) begin
            r = $random(seed);
            run_cycle({20'h00006, r[11:2], 2'b00}, RET_WORD, 1'b0, 1'b0, '0,
                      1'b1, {r[31:2], 2'b00}, 1'b0);
        end
        for (int n = 0; n < 4; n++) begin
            r = $random(seed);
            run_cycle({20'h00006, r[11:2], 2'b00}, RET_WORD, 1'b1, 1'b1, '0,
                      1'b1, {r[31:2], 2'b00}, 1'b1);
        end
        for (int n = 0; n < 34; n++) begin
            r = $random(seed);
            run_cycle({20'h00006, r[11:2], 2'b00}, RET_WORD, 1'b1, 1'b1, {r[31:2], 2'b00},
                      1'b0, '0, 1'b0);
        end
        run_cycle(32'h0000_6000, RET_WORD, 1'b0, 1'b0, '0, 1'b0, '0, 1'b0);
        check_val("pdt_res_o", 32'(pdt_res), 32'h0);

        for (int n = 0; n < 500; n++) begin
            r  = $random(seed);
            r2 = $random(seed);
            run_cycle({20'h00006, r[11:2], 2'b00}, RET_WORD, r[12], r[13], {r2[31:2], 2'b00},
                      r[14], {r2[15:0], r[31:18], 2'b00}, r[16] & r[17]);
        end

        $display("ALL CHECKS PASSED");
        $finish;
    end

endmodule

//--- bpu.f
+incdir+bench
logic/bpu_pkg.sv
logic/inst_decoder.sv
logic/tage_direction.sv
logic/branch_target_buffer.sv
logic/return_stack.sv
logic/pred_select.sv
logic/bpu.sv
bench/tb_bpu.sv

//--- run.sh
#!/usr/bin/env bash
# build and run the branch predictor testbench with verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing -f bpu.f --top-module tb_bpu -o tb_bpu_sim
if [ $? -ne 0 ]; then
    echo "verilator build failed"
    exit 1
fi

./obj_dir/tb_bpu_sim > sim.log 2>&1
sim_status=$?
cat sim.log
if [ $sim_status -ne 0 ]; then
    echo "simulation exited with status $sim_status"
    exit 1
fi

if grep -q "ALL CHECKS PASSED" sim.log; then
    echo "simulation passed"
    exit 0
fi
echo "simulation failed"
exit 1
